// File: mem_ctrl_pkg.sv
package mem_ctrl_pkg;

  // ********************
  // bus and field widths
  // ********************

  localparam int ADDR_W    = 32;      // byte address and stride
  localparam int TX_SIZE_W = 10;      // request and response sizes
  localparam int LOOP_W    = 8;       // trip counts
  localparam int CFG_IDX_W = 2;       // config table index

  // last used entry of the config table
  localparam int CFG_LAST  = 3;

  // ********************
  // width types
  // ********************

  // byte address, also used for strides
  typedef logic [ADDR_W-1:0]    addr_t;

  // request size or expected response size
  typedef logic [TX_SIZE_W-1:0] tx_size_t;

  // loop count or loop maximum
  typedef logic [LOOP_W-1:0]    loop_t;

  // config table index
  typedef logic [CFG_IDX_W-1:0] cfg_idx_t;

endpackage

// File: rd_cfg_pkg.sv
package rd_cfg_pkg;
  import mem_ctrl_pkg::*;

  // ********************
  // config table entry
  // ********************

  // buffer phase, one run of strided reads
  typedef struct packed {
    addr_t    base;         // first buffer address
    addr_t    stride;       // distance between reads
    loop_t    last;         // reads minus one
    tx_size_t size;         // request size
    tx_size_t rvalid_size;  // expected response size
  } buffer_cfg_t;

  // stream phase, three nested loops, loop 0 innermost
  typedef struct packed {
    addr_t    base;
    tx_size_t size;
    tx_size_t rvalid_size;
    addr_t    stride0;
    addr_t    stride1;
    addr_t    stride2;
    loop_t    last0;
    loop_t    last1;
    loop_t    last2;
  } stream_cfg_t;

  // one line of rd_cfg.mem, msb first
  typedef struct packed {
    buffer_cfg_t buffer;
    stream_cfg_t stream;
  } rd_cfg_t;

  // ********************
  // read request
  // ********************

  typedef struct packed {
    addr_t    addr;
    tx_size_t size;
    tx_size_t rvalid_size;
    loop_t    pu_id;        // zero on stream reads
    logic     is_buffer;    // buffer read, else stream read
  } rd_info_t;

endpackage

// File: loop_counter.sv
`timescale 1ns/10ps

// up-counter that wraps to zero after a run-time maximum
module loop_counter #(
  parameter int COUNT_W = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               clear,   // back to zero, wins over step
  input  logic               step,
  input  logic [COUNT_W-1:0] last,    // highest count before wrap
  output logic [COUNT_W-1:0] count,
  output logic               at_max
);

  logic [COUNT_W-1:0] count_next;

  assign at_max = (count == last);

  always_comb begin
    count_next = count;
    if (clear) begin
      count_next = '0;
    end else if (step) begin
      if (at_max) begin
        count_next = '0;              // wrap
      end else begin
        count_next = count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

endmodule

// File: rd_cfg_rom.sv
`timescale 1ns/10ps

// read config table, one-cycle registered read
module rd_cfg_rom
  import mem_ctrl_pkg::*;
  import rd_cfg_pkg::*;
(
  input  logic     clk,
  input  cfg_idx_t idx,
  output rd_cfg_t  cfg
);

  // ********************
  // table storage
  // ********************

  logic [$bits(rd_cfg_t)-1:0] table_mem [0:CFG_LAST];

  initial begin
    $readmemb("rd_cfg.mem", table_mem);
  end

  // a writable table could replace this read port later
  always_ff @(posedge clk) begin
    cfg <= rd_cfg_t'(table_mem[idx]);
  end

endmodule

// File: buffer_addr_gen.sv
`timescale 1ns/10ps

// buffer phase, evenly spaced reads, one per processing unit
module buffer_addr_gen
  import mem_ctrl_pkg::*;
  import rd_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        apply,        // load base, clear count
  input  logic        step,         // one buffer read issued
  input  buffer_cfg_t cfg,
  output addr_t       addr,
  output loop_t       pu_id,
  output logic        buffer_last   // current read is the last one
);

  // ********************
  // read counter
  // ********************

  // the count doubles as the processing-unit id
  loop_counter #(
    .COUNT_W (LOOP_W)
  ) u_buffer_count (
    .clk    (clk),
    .reset  (reset),
    .clear  (apply),
    .step   (step),
    .last   (cfg.last),
    .count  (pu_id),
    .at_max (buffer_last)
  );

  // ********************
  // address
  // ********************

  always_ff @(posedge clk) begin
    if (apply) begin
      addr <= cfg.base;               // first read of the run
    end else if (step) begin
      addr <= addr + cfg.stride;      // wraps modulo 2**32
    end
  end

endmodule

// File: stream_addr_gen.sv
`timescale 1ns/10ps

// stream phase, three nested loops with their own strides
module stream_addr_gen
  import mem_ctrl_pkg::*;
  import rd_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        apply,        // load base, clear all loops
  input  logic        step,         // one stream read issued
  input  stream_cfg_t cfg,
  output addr_t       addr,
  output logic        stream_last   // all three loops at their maximum
);

  logic  inner_max;
  logic  middle_max;
  logic  outer_max;
  logic  middle_step;
  logic  outer_step;
  addr_t middle_start;              // start of the current middle pass
  addr_t outer_start;               // start of the current outer pass
  addr_t middle_start_next;
  addr_t outer_start_next;

  // a level steps once every level inside it wraps
  assign middle_step = step && inner_max;
  assign outer_step  = middle_step && middle_max;
  assign stream_last = inner_max && middle_max && outer_max;

  // ********************
  // loop counters
  // ********************

  // only the at_max flags are needed here
  loop_counter #(
    .COUNT_W (LOOP_W)
  ) u_inner (
    .clk    (clk),
    .reset  (reset),
    .clear  (apply),
    .step   (step),
    .last   (cfg.last0),
    .count  (),
    .at_max (inner_max)
  );

  loop_counter #(
    .COUNT_W (LOOP_W)
  ) u_middle (
    .clk    (clk),
    .reset  (reset),
    .clear  (apply),
    .step   (middle_step),
    .last   (cfg.last1),
    .count  (),
    .at_max (middle_max)
  );

  loop_counter #(
    .COUNT_W (LOOP_W)
  ) u_outer (
    .clk    (clk),
    .reset  (reset),
    .clear  (apply),
    .step   (outer_step),
    .last   (cfg.last2),
    .count  (),
    .at_max (outer_max)
  );

  // ********************
  // addresses
  // ********************

  always_comb begin
    outer_start_next  = outer_max ? cfg.base : outer_start + cfg.stride2;
    middle_start_next = middle_start + cfg.stride1;
  end

  always_ff @(posedge clk) begin
    if (apply) begin
      addr         <= cfg.base;
      middle_start <= cfg.base;
      outer_start  <= cfg.base;
    end else if (outer_step) begin
      // inner levels restart from the new outer start
      addr         <= outer_start_next;
      middle_start <= outer_start_next;
      outer_start  <= outer_start_next;
    end else if (middle_step) begin
      addr         <= middle_start_next;
      middle_start <= middle_start_next;
    end else if (step) begin
      addr         <= addr + cfg.stride0;   // inner stride
    end
  end

endmodule

// File: rd_ctrl_fsm.sv
`timescale 1ns/10ps

// read sequencer, table fetch then buffer phase then stream phase
module rd_ctrl_fsm (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic rd_ready,
  input  logic buffer_last,
  input  logic stream_last,
  input  logic at_max,        // entry counter on last table entry
  output logic apply,
  output logic buffer_step,
  output logic stream_step,
  output logic next_entry,
  output logic is_buffer,
  output logic rd_req,
  output logic done
);

  typedef enum logic [2:0] {
    idle,
    fetch_cfg,                // table read in flight
    apply_cfg,                // table output valid
    busy_buffer,
    busy_stream
  } rd_state_t;

  rd_state_t state;
  rd_state_t state_next;

  // ********************
  // strobes
  // ********************

  assign apply       = (state == apply_cfg);
  assign is_buffer   = (state == busy_buffer);
  assign buffer_step = is_buffer && rd_ready;
  assign stream_step = (state == busy_stream) && rd_ready;
  assign rd_req      = buffer_step || stream_step;
  assign next_entry  = stream_step && stream_last;

  // ********************
  // next state
  // ********************

  always_comb begin
    state_next = state;
    case (state)
      idle:        if (start) state_next = fetch_cfg;   // start ignored elsewhere
      fetch_cfg:   state_next = apply_cfg;
      apply_cfg:   state_next = busy_buffer;
      busy_buffer: if (buffer_step && buffer_last) state_next = busy_stream;
      busy_stream: begin
        if (next_entry) begin
          state_next = at_max ? idle : fetch_cfg;
        end
      end
      default:     state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      done  <= next_entry && at_max;  // cycle after the final read
    end
  end

endmodule

// File: mem_read_ctrl.sv
`timescale 1ns/10ps

// read side of the memory request controller
module mem_read_ctrl
  import mem_ctrl_pkg::*;
  import rd_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     start,
  input  logic     rd_ready,
  output logic     rd_req,
  output rd_info_t rd_info,
  output logic     done
);

  cfg_idx_t cfg_idx;
  rd_cfg_t  cfg;
  logic     at_max;
  logic     apply;
  logic     buffer_step;
  logic     stream_step;
  logic     next_entry;
  logic     is_buffer;
  logic     buffer_last;
  logic     stream_last;
  addr_t    buffer_addr;
  addr_t    stream_addr;
  loop_t    buffer_pu_id;

  // ********************
  // config table
  // ********************

  // wraps back to entry 0 after the last entry
  loop_counter #(
    .COUNT_W (CFG_IDX_W)
  ) u_entry_count (
    .clk    (clk),
    .reset  (reset),
    .clear  (1'b0),
    .step   (next_entry),
    .last   (cfg_idx_t'(CFG_LAST)),
    .count  (cfg_idx),
    .at_max (at_max)
  );

  rd_cfg_rom u_rd_cfg_rom (
    .clk (clk),
    .idx (cfg_idx),
    .cfg (cfg)
  );

  // ********************
  // sequencer
  // ********************

  rd_ctrl_fsm u_rd_ctrl_fsm (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .rd_ready    (rd_ready),
    .buffer_last (buffer_last),
    .stream_last (stream_last),
    .at_max      (at_max),
    .apply       (apply),
    .buffer_step (buffer_step),
    .stream_step (stream_step),
    .next_entry  (next_entry),
    .is_buffer   (is_buffer),
    .rd_req      (rd_req),
    .done        (done)
  );

  // ********************
  // address generators
  // ********************

  buffer_addr_gen u_buffer_addr_gen (
    .clk         (clk),
    .reset       (reset),
    .apply       (apply),
    .step        (buffer_step),
    .cfg         (cfg.buffer),
    .addr        (buffer_addr),
    .pu_id       (buffer_pu_id),
    .buffer_last (buffer_last)
  );

  stream_addr_gen u_stream_addr_gen (
    .clk         (clk),
    .reset       (reset),
    .apply       (apply),
    .step        (stream_step),
    .cfg         (cfg.stream),
    .addr        (stream_addr),
    .stream_last (stream_last)
  );

  // request fields, valid while rd_req is high
  always_comb begin
    rd_info.is_buffer = is_buffer;
    if (is_buffer) begin
      rd_info.addr        = buffer_addr;
      rd_info.size        = cfg.buffer.size;
      rd_info.rvalid_size = cfg.buffer.rvalid_size;
      rd_info.pu_id       = buffer_pu_id;
    end else begin
      rd_info.addr        = stream_addr;
      rd_info.size        = cfg.stream.size;
      rd_info.rvalid_size = cfg.stream.rvalid_size;
      rd_info.pu_id       = '0;           // streams go to every unit
    end
  end

endmodule

// File: rd_monitor.sv
`timescale 1ns/10ps

// watches the read requests and compares them with the configured sequence
module rd_monitor
  import mem_ctrl_pkg::*;
  import rd_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     start,
  input  logic     rd_ready,
  input  logic     rd_req,
  input  rd_info_t rd_info,
  input  logic     done,
  input  int       test_num,
  output int       value_errors,
  output int       protocol_errors,
  output int       requests,        // all requests seen so far
  output int       done_count
);

  logic [$bits(rd_cfg_t)-1:0] cfg_mem [0:CFG_LAST];
  rd_info_t expected_q [$];            // requests still due in this run
  int       value_err_cnt = 0;
  int       protocol_err_cnt = 0;
  int       request_cnt = 0;
  int       done_cnt = 0;
  int       run_len = 0;
  int       run_reqs = 0;
  bit       active = 1'b0;             // mirrors the sequencer leaving idle
  bit       done_prev = 1'b0;

  assign value_errors    = value_err_cnt;
  assign protocol_errors = protocol_err_cnt;
  assign requests        = request_cnt;
  assign done_count      = done_cnt;

  initial begin
    $readmemb("rd_cfg.mem", cfg_mem);
  end

  function automatic string test_name(int num);
    case (num)
      1:       return "reset_idle";
      2:       return "ready_high";
      3:       return "ready_random";
      4:       return "repeat_run";
      5:       return "start_mid_run";
      default: return "setup";
    endcase
  endfunction

  // ********************
  // reference model
  // ********************

  // one full run, every entry buffer phase first then stream phase
  function automatic void build_expected_list();
    rd_cfg_t  entry;
    rd_info_t req;
    int       e;
    int       k;
    int       o;
    int       m;
    int       i;
    expected_q.delete();
    for (e = 0; e <= CFG_LAST; e++) begin
      entry = rd_cfg_t'(cfg_mem[cfg_idx_t'(e)]);
      for (k = 0; k <= int'(entry.buffer.last); k++) begin
        req.addr        = entry.buffer.base + addr_t'(k) * entry.buffer.stride;
        req.size        = entry.buffer.size;
        req.rvalid_size = entry.buffer.rvalid_size;
        req.pu_id       = loop_t'(k);
        req.is_buffer   = 1'b1;
        expected_q.push_back(req);
      end
      for (o = 0; o <= int'(entry.stream.last2); o++) begin    // outer loop slowest
        for (m = 0; m <= int'(entry.stream.last1); m++) begin
          for (i = 0; i <= int'(entry.stream.last0); i++) begin
            req.addr        = entry.stream.base
                            + addr_t'(o) * entry.stream.stride2
                            + addr_t'(m) * entry.stream.stride1
                            + addr_t'(i) * entry.stream.stride0;
            req.size        = entry.stream.size;
            req.rvalid_size = entry.stream.rvalid_size;
            req.pu_id       = '0;
            req.is_buffer   = 1'b0;
            expected_q.push_back(req);
          end
        end
      end
    end
  endfunction

  task automatic check_field(string field, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      value_err_cnt++;
      $display("error %s request %0d %s expected %h actual %h at %0t",
               test_name(test_num), run_reqs, field, expected, actual, $time);
    end
  endtask

  task automatic protocol_error(string what);
    protocol_err_cnt++;
    $display("%s in test %s at %0t", what, test_name(test_num), $time);
  endtask

  // ********************
  // compare on each edge
  // ********************

  always @(posedge clk) begin
    rd_info_t head;
    if (!reset) begin
      if (rd_req) begin
        request_cnt++;
        if (!rd_ready) protocol_error("rd_req high while rd_ready low");
        if (!active) begin
          protocol_error("read request while no run is active");
        end else if (expected_q.size() == 0) begin
          protocol_error("more read requests than the table describes");
        end else begin
          head = expected_q.pop_front();
          check_field("addr", head.addr, rd_info.addr);
          check_field("size", 32'(head.size), 32'(rd_info.size));
          check_field("rvalid_size", 32'(head.rvalid_size), 32'(rd_info.rvalid_size));
          check_field("pu_id", 32'(head.pu_id), 32'(rd_info.pu_id));
          check_field("is_buffer", 32'(head.is_buffer), 32'(rd_info.is_buffer));
          run_reqs++;
        end
      end
      if (done) begin
        done_cnt++;
        if (done_prev) begin
          protocol_error("done high for more than one cycle");
        end else if (!active) begin
          protocol_error("done pulsed while no run is active");
        end else if (run_reqs != run_len) begin
          protocol_error($sformatf("done after %0d of %0d requests", run_reqs, run_len));
        end
        active = 1'b0;                 // sequencer is idle again
      end
      if (start && !active) begin      // start is only taken in idle
        build_expected_list();
        run_len  = expected_q.size();
        run_reqs = 0;
        active   = 1'b1;
      end
      done_prev = done;
    end
  end

endmodule

// File: tb_top.sv
`timescale 1ns/10ps

module tb_top
  import mem_ctrl_pkg::*;
  import rd_cfg_pkg::*;
();

  logic     clk;
  logic     reset;
  logic     start;
  logic     rd_ready;
  logic     rd_req;
  rd_info_t rd_info;
  logic     done;
  int       test_num;
  int       ready_mode;                // 0 low, 1 high, 2 random
  int       value_errors;
  int       protocol_errors;
  int       requests;
  int       done_count;
  int       run_errors = 0;
  int       timeouts = 0;
  int       runs = 0;

  mem_read_ctrl dut0 (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .rd_ready (rd_ready),
    .rd_req   (rd_req),
    .rd_info  (rd_info),
    .done     (done)
  );

  rd_monitor mon0 (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .rd_ready        (rd_ready),
    .rd_req          (rd_req),
    .rd_info         (rd_info),
    .done            (done),
    .test_num        (test_num),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .requests        (requests),
    .done_count      (done_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;             // 8 ns period
  end

  // ********************
  // helper tasks
  // ********************

  task automatic next_cycle();
    @(posedge clk);
    #1;                                // inputs change just after the edge
  endtask

  task automatic idle_cycles(int n);
    repeat (n) next_cycle();
  endtask

  task automatic end_simulation();
    $display("value errors %0d, protocol errors %0d, run errors %0d, timeouts %0d",
             value_errors, protocol_errors, run_errors, timeouts);
    if (value_errors + protocol_errors + run_errors + timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  task automatic wait_for_done(input int max_cycles, output bit ok);
    int cycles;
    cycles = 0;
    while (done !== 1'b1 && cycles < max_cycles) begin
      next_cycle();
      cycles++;
    end
    ok = (done === 1'b1);
    if (!ok) begin
      $display("timeout waiting for done in test %0d after %0d cycles", test_num, cycles);
      timeouts++;
    end
  endtask

  task automatic wait_for_requests(input int target, input int max_cycles, output bit ok);
    int cycles;
    cycles = 0;
    while (requests < target && cycles < max_cycles) begin
      next_cycle();
      cycles++;
    end
    ok = (requests >= target);
    if (!ok) begin
      $display("timeout waiting for %0d requests in test %0d", target, test_num);
      timeouts++;
    end
  endtask

  task automatic run_one(output bit ok);
    pulse_start();
    wait_for_done(3000, ok);
    runs++;
  endtask

  // rd_ready level held or random per test
  initial begin
    int mode;
    void'($urandom(32'h9cc4be89));
    rd_ready = 1'b0;
    forever begin
      @(posedge clk);
      mode = ready_mode;               // settled since the last edge
      #1;
      case (mode)
        1:       rd_ready = 1'b1;
        2:       rd_ready = ($urandom % 3) != 0;
        default: rd_ready = 1'b0;
      endcase
    end
  end

  // ********************
  // test sequence
  // ********************

  task automatic run_tests();
    bit ok;
    test_num   = 1;                    // no start so any request is an error
    ready_mode = 2;
    idle_cycles(20);

    test_num   = 2;
    ready_mode = 1;
    run_one(ok);
    if (!ok) return;

    test_num   = 3;
    ready_mode = 2;
    run_one(ok);
    if (!ok) return;

    test_num   = 4;                    // starts in the done cycle
    ready_mode = 1;
    run_one(ok);
    if (!ok) return;

    test_num   = 5;
    ready_mode = 2;
    pulse_start();
    wait_for_requests(requests + 10, 500, ok);
    if (!ok) return;
    pulse_start();                     // sequencer busy so this start is ignored
    wait_for_done(3000, ok);
    if (!ok) return;
    runs++;

    idle_cycles(20);
    if (done_count != runs) begin
      run_errors++;
      $display("done pulsed %0d times over %0d runs", done_count, runs);
    end
  endtask

  initial begin
    reset      = 1'b1;
    start      = 1'b0;
    test_num   = 0;
    ready_mode = 0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    run_tests();
    end_simulation();
  end

endmodule

// File: rd_cfg.mem
// buffer fields base stride last size rvalid_size, msb first
// then stream fields base size rvalid_size stride0 stride1 stride2 last0 last1 last2
000000000000000000010000000000000000000000000000000000000100000000000011000001000000000001000000000000000001000000000000000000000010000000000010000000000000000000000000000000000100000000000000000000000100000000000000000000000001000000000000000000100000000100000001
111111111111111111111111111100000000000000000000000000000001000000000010000010000000000010000000000000100000000000000000000000000001000000000100000000000000000000000000000010000000000000000000000000001000000000000000000000000001000000000000000000010000001000000000
000000000000000000000001000000000000000000000000000000000010000000000000000000000100000000010000000000110000000000000000000000010000000000010000000000000000000000000000000000010000000000000000000000000001000000000000000000000000001000000000000000000000000100000010
000000000000000000100000000000000000000000000000000000000000100000000001000000001000000000100000000001000000000000000000000000000011000000000011000000000000000000000000000000100000000000000000000000000010000000000000000000000000100000000000000000010000000100000001

// File: tb.f
mem_ctrl_pkg.sv
rd_cfg_pkg.sv
loop_counter.sv
rd_cfg_rom.sv
buffer_addr_gen.sv
stream_addr_gen.sv
rd_ctrl_fsm.sv
mem_read_ctrl.sv
rd_monitor.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -f tb.f --top-module tb_top -o tb_top_sim

./obj_dir/tb_top_sim | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "failure found in sim.log"
  exit 1
fi

echo "no failure found in sim.log"
